/* hdl/cpu_types_pkg.sv */
// CPU datapath types: word and register widths plus the writeback select codes
package cpu_types_pkg;

  // Width of a data word, a PC value and an ALU result
  localparam int WORD_W = 32;

  // Register number width and the register file depth that follows from it
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 1 << REG_ADDR_W;

  // Width of the MemtoReg field
  localparam int WB_SEL_W = 2;

  // Distance from an instruction's PC to the next one, used for link writes
  localparam int PC_STEP = 4;

  // A data word as it moves through the pipeline
  typedef logic [WORD_W-1:0] word_t;

  // A register file index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // The writeback source select field
  typedef logic [WB_SEL_W-1:0] wb_sel_t;

  // Writeback select codes
  // Code 2'b11 is reserved and is treated the same as WB_ALU
  localparam wb_sel_t WB_ALU = 2'b00;
  localparam wb_sel_t WB_MEM = 2'b01;
  localparam wb_sel_t WB_PC4 = 2'b10;

endpackage

/* hdl/mem_cfg_pkg.sv */
// Data memory configuration: depth, word address width and address type
package mem_cfg_pkg;

  // Number of word address bits, which sets the memory size
  localparam int RAM_ADDR_W = 8;
  localparam int RAM_DEPTH = 1 << RAM_ADDR_W;

  // Low byte address bits dropped to form a word address
  localparam int BYTE_OFFSET_W = 2;

  // A word index into the data memory
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

endpackage

/* hdl/wb_if.sv */
// MEM/WB stage bundle from the stage register to the writeback logic
`timescale 1ns/1ps

interface wb_if
  import cpu_types_pkg::*;
();

  // Register file write enable of the instruction in writeback
  logic reg_write;

  // PC of the instruction, needed for link writes
  word_t pc;

  // Result from the execute stage, also the memory address
  word_t alu_out;

  // Destination register number
  reg_addr_t addr_c;

  // Writeback source select
  wb_sel_t mem_to_reg;

  // The stage register owns every field
  modport stage (output reg_write, pc, alu_out, addr_c, mem_to_reg);

  // The writeback logic only reads them
  modport sink (input reg_write, pc, alu_out, addr_c, mem_to_reg);

endinterface

/* hdl/mem_wb_reg.sv */
// MEM/WB pipeline register carrying control, ALU result and PC into writeback
`timescale 1ns/1ps

module mem_wb_reg
  import cpu_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      reg_write_in,
  input  word_t     pc_in,
  input  word_t     alu_out_in,
  input  reg_addr_t addr_c_in,
  input  wb_sel_t   mem_to_reg_in,
  wb_if.stage       stage
);

  // Control fields
  // Clearing reg_write on reset keeps the register file from being written
  // by whatever happens to sit in the stage during reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage.reg_write  <= 1'b0;
      stage.addr_c     <= '0;
      stage.mem_to_reg <= WB_ALU;
    end else begin
      stage.reg_write  <= reg_write_in;
      stage.addr_c     <= addr_c_in;
      stage.mem_to_reg <= mem_to_reg_in;
    end
  end

  // Datapath fields
  // These are cleared as well so the whole stage reads zero in reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage.pc      <= '0;
      stage.alu_out <= '0;
    end else begin
      stage.pc      <= pc_in;
      stage.alu_out <= alu_out_in;
    end
  end

endmodule

/* hdl/data_ram.sv */
// Word-addressed data memory with synchronous write and registered read
`timescale 1ns/1ps

module data_ram
  import cpu_types_pkg::*;
  import mem_cfg_pkg::*;
(
  input  logic  clk,
  input  logic  mem_write,
  input  word_t addr,
  input  word_t store_data,
  output word_t rdata
);

  // Storage array, one entry per word
  word_t mem [RAM_DEPTH];

  // Word index taken from the byte address
  ram_addr_t word_addr;

  // Only bits 9 down to 2 select a word, the rest of the address is ignored
  // so accesses above the memory size wrap around
  assign word_addr = addr[BYTE_OFFSET_W +: RAM_ADDR_W];

  // Write port
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[word_addr] <= store_data;
    end
  end

  // Read port
  // The read samples the array before the write in the same edge lands,
  // so a read and write to one word return the old contents
  // Registering here lines the data up with the MEM/WB register outputs
  always_ff @(posedge clk) begin
    rdata <= mem[word_addr];
  end

endmodule

/* hdl/write_back.sv */
// Writeback source select and the 32-entry register file
`timescale 1ns/1ps

module write_back
  import cpu_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  wb_if.sink        wb,
  input  word_t     mem_rdata,
  input  reg_addr_t raddr,
  output word_t     rdata,
  output logic      wb_en,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  // Register file storage
  word_t regs [NUM_REGS];

  // Return address for link instructions
  word_t pc_plus4;

  // Write strobe actually applied to the register file
  logic rf_we;

  assign pc_plus4 = wb.pc + word_t'(PC_STEP);

  // Writeback port follows the stage register directly
  assign wb_en   = wb.reg_write;
  assign wb_addr = wb.addr_c;

  // Source select
  // The reserved code falls into the default arm and writes the ALU result
  always_comb begin
    case (wb.mem_to_reg)
      WB_MEM:  wb_data = mem_rdata;
      WB_PC4:  wb_data = pc_plus4;
      WB_ALU:  wb_data = wb.alu_out;
      default: wb_data = wb.alu_out;
    endcase
  end

  // Register 0 is hardwired, so writes to it are dropped here
  assign rf_we = wb_en && (wb_addr != '0);

  // Register file write port
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // Debug read port, combinational from the address
  // Entry 0 is never written, but the explicit zero keeps register 0
  // independent of the storage
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs[raddr];
    end
  end

endmodule

/* hdl/mem_wb_path.sv */
// Memory access and writeback end of the pipeline around the MEM/WB register
`timescale 1ns/1ps

module mem_wb_path
  import cpu_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // Memory stage fields of the instruction entering this cycle
  input  logic      reg_write_in,
  input  word_t     pc_in,
  input  word_t     alu_out_in,
  input  reg_addr_t addr_c_in,
  input  wb_sel_t   mem_to_reg_in,

  // Store request for the data memory
  input  logic      mem_write,
  input  word_t     store_data,

  // Debug read of the register file
  input  reg_addr_t raddr,
  output word_t     rdata,

  // Writeback port
  output logic      wb_en,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  // Fields leaving the MEM/WB register
  wb_if wb_bus ();

  // Loaded word, valid in the same cycle as the wb_bus fields
  word_t mem_rdata;

  mem_wb_reg u_mem_wb_reg (
    .clk           (clk),
    .rst           (rst),
    .reg_write_in  (reg_write_in),
    .pc_in         (pc_in),
    .alu_out_in    (alu_out_in),
    .addr_c_in     (addr_c_in),
    .mem_to_reg_in (mem_to_reg_in),
    .stage         (wb_bus.stage)
  );

  // The memory is addressed by the current ALU result, in parallel with
  // the stage register capturing the same instruction
  data_ram u_data_ram (
    .clk        (clk),
    .mem_write  (mem_write),
    .addr       (alu_out_in),
    .store_data (store_data),
    .rdata      (mem_rdata)
  );

  write_back u_write_back (
    .clk       (clk),
    .rst       (rst),
    .wb        (wb_bus.sink),
    .mem_rdata (mem_rdata),
    .raddr     (raddr),
    .rdata     (rdata),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

endmodule

/* tests/mem_wb_reg_props.sv */
// Assertions on the MEM/WB stage register for passthrough, reset clear and unknown values
`timescale 1ns/1ps

module mem_wb_reg_props
  import cpu_types_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      reg_write_in,
  input word_t     pc_in,
  input word_t     alu_out_in,
  input reg_addr_t addr_c_in,
  input wb_sel_t   mem_to_reg_in,
  input logic      reg_write,
  input word_t     pc,
  input word_t     alu_out,
  input reg_addr_t addr_c,
  input wb_sel_t   mem_to_reg
);

  localparam int STAGE_W = 1 + 2 * WORD_W + REG_ADDR_W + WB_SEL_W;

  logic [STAGE_W-1:0] d_bus;
  logic [STAGE_W-1:0] q_bus;

  // Running count of assertion failures
  int fail_count = 0;

  assign d_bus = {reg_write_in, pc_in, alu_out_in, addr_c_in, mem_to_reg_in};
  assign q_bus = {reg_write, pc, alu_out, addr_c, mem_to_reg};

  passthrough_a: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> q_bus == $past(d_bus))
    else begin
      fail_count++;
      $error("MEM/WB outputs differ from the inputs of the previous cycle");
    end

  // Checked on the falling edge, after the first rising edge has cleared the stage
  reset_clear_a: assert property (@(negedge clk) rst |-> q_bus == '0)
    else begin
      fail_count++;
      $error("MEM/WB outputs are not zero while reset is high");
    end

  known_a: assert property (@(posedge clk) disable iff (rst) !$isunknown(q_bus))
    else begin
      fail_count++;
      $error("MEM/WB outputs hold an unknown value");
    end

endmodule

bind mem_wb_reg mem_wb_reg_props u_props (
  .clk           (clk),
  .rst           (rst),
  .reg_write_in  (reg_write_in),
  .pc_in         (pc_in),
  .alu_out_in    (alu_out_in),
  .addr_c_in     (addr_c_in),
  .mem_to_reg_in (mem_to_reg_in),
  .reg_write     (stage.reg_write),
  .pc            (stage.pc),
  .alu_out       (stage.alu_out),
  .addr_c        (stage.addr_c),
  .mem_to_reg    (stage.mem_to_reg)
);

/* tests/mem_wb_checker.sv */
// Checker for the MEM/WB path with reference models of memory and register file
`timescale 1ns/1ps

module mem_wb_checker
  import cpu_types_pkg::*;
  import mem_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      reg_write_in,
  input  word_t     pc_in,
  input  word_t     alu_out_in,
  input  reg_addr_t addr_c_in,
  input  wb_sel_t   mem_to_reg_in,
  input  logic      mem_write,
  input  word_t     store_data,
  input  reg_addr_t raddr,
  input  word_t     rdata,
  input  logic      wb_en,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data,
  output int        value_errors,
  output int        checks
);

  // Model memory, with a flag per word once its contents are known
  word_t     model_mem [RAM_DEPTH];
  bit        mem_known [RAM_DEPTH];
  word_t     model_regs [NUM_REGS];

  // Expected writeback of the instruction captured at the next rising edge
  logic      exp_en;
  reg_addr_t exp_addr;
  word_t     exp_data;
  bit        exp_known;

  ram_addr_t cur_widx;
  word_t     loaded;

  // Writeback value from the select code
  // Reserved code 11 acts as ALU
  function automatic word_t wb_value(wb_sel_t sel, word_t alu, word_t mem_word, word_t pc);
    case (sel)
      2'b01:   return mem_word;
      2'b10:   return pc + 32'd4;
      default: return alu;
    endcase
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  initial begin
    value_errors = 0;
    checks = 0;
    foreach (model_regs[i]) model_regs[i] = '0;
  end

  // Everything is sampled on the falling edge, half a cycle away from any change
  always @(negedge clk) begin
    if (rst) begin
      foreach (model_regs[i]) model_regs[i] = '0;
      exp_en = 1'b0;
      exp_addr = '0;
      exp_data = '0;
      exp_known = 1'b1;
      check_value("wb_en", 32'(1'b0), 32'(wb_en));
      check_value("rdata", '0, rdata);
    end else begin
      // The register file still holds the state before this cycle's writeback
      check_value("rdata", (raddr == '0) ? '0 : model_regs[raddr], rdata);
      check_value("wb_en", 32'(exp_en), 32'(wb_en));
      check_value("wb_addr", 32'(exp_addr), 32'(wb_addr));
      if (exp_known) begin
        check_value("wb_data", exp_data, wb_data);
      end
      if (exp_en && exp_addr != '0) begin
        model_regs[exp_addr] = exp_data;
      end

      // Memory read sees the word before a write in the same cycle
      cur_widx = alu_out_in[9:2];
      loaded = model_mem[cur_widx];
      exp_known = (mem_to_reg_in != 2'b01) || mem_known[cur_widx];
      if (mem_write) begin
        model_mem[cur_widx] = store_data;
        mem_known[cur_widx] = 1'b1;
      end
      exp_en = reg_write_in;
      exp_addr = addr_c_in;
      exp_data = wb_value(mem_to_reg_in, alu_out_in, loaded, pc_in);
    end
  end

endmodule

/* tests/mem_wb_path_tb.sv */
// Testbench for the MEM/WB path: clock, reset, directed and random stimulus, timeout
`timescale 1ns/1ps

module mem_wb_path_tb;
  import cpu_types_pkg::*;
  import mem_cfg_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_STORED = 16;
  localparam int DIRECTED_LEN = 2 * NUM_STORED + 3;
  localparam int RANDOM_LEN = 400;
  localparam int DRAIN_CYCLES = 3;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_REGS + DIRECTED_LEN + RANDOM_LEN
                                  + 2 * DRAIN_CYCLES + 100;

  logic      clk;
  logic      rst;
  logic      reg_write_in;
  word_t     pc_in;
  word_t     alu_out_in;
  reg_addr_t addr_c_in;
  wb_sel_t   mem_to_reg_in;
  logic      mem_write;
  word_t     store_data;
  reg_addr_t raddr;
  word_t     rdata;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  integer    seed;
  word_t     pc_next;
  ram_addr_t written[$];
  int        value_errors;
  int        checks;
  int        prop_errors;
  int        cycle_count;

  mem_wb_path DUT (
    .clk (clk), .rst (rst),
    .reg_write_in (reg_write_in), .pc_in (pc_in), .alu_out_in (alu_out_in),
    .addr_c_in (addr_c_in), .mem_to_reg_in (mem_to_reg_in),
    .mem_write (mem_write), .store_data (store_data),
    .raddr (raddr), .rdata (rdata),
    .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data)
  );

  mem_wb_checker u_checker (
    .clk (clk), .rst (rst),
    .reg_write_in (reg_write_in), .pc_in (pc_in), .alu_out_in (alu_out_in),
    .addr_c_in (addr_c_in), .mem_to_reg_in (mem_to_reg_in),
    .mem_write (mem_write), .store_data (store_data),
    .raddr (raddr), .rdata (rdata),
    .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data),
    .value_errors (value_errors), .checks (checks)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // Random upper bits show that only bits 9 to 2 pick the word
  function automatic word_t addr_for(ram_addr_t idx);
    word_t w;
    w = rand_word();
    w[9:2] = idx;
    w[1:0] = 2'b00;
    return w;
  endfunction

  function automatic word_t next_pc();
    pc_next = pc_next + 32'd4;
    return pc_next;
  endfunction

  task automatic drive_instr(input logic rw, input word_t pc, input word_t alu,
                             input reg_addr_t rd, input wb_sel_t sel, input logic mw,
                             input word_t sd, input reg_addr_t ra);
    @(posedge clk);
    reg_write_in  <= rw;
    pc_in         <= pc;
    alu_out_in    <= alu;
    addr_c_in     <= rd;
    mem_to_reg_in <= sel;
    mem_write     <= mw;
    store_data    <= sd;
    raddr         <= ra;
  endtask

  task automatic sweep_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      drive_instr(1'b0, '0, '0, '0, WB_ALU, 1'b0, '0, reg_addr_t'(r));
    end
  endtask

  task automatic directed_phase();
    ram_addr_t idx;
    for (int i = 0; i < NUM_STORED; i++) begin
      idx = ram_addr_t'(i * 13 + 5);
      written.push_back(idx);
      drive_instr(1'b0, next_pc(), addr_for(idx), '0, WB_ALU, 1'b1, rand_word(),
                  reg_addr_t'(i));
    end
    for (int i = 0; i < NUM_STORED; i++) begin
      drive_instr(1'b1, next_pc(), addr_for(written[i]), reg_addr_t'(i + 1), WB_MEM,
                  1'b0, '0, reg_addr_t'(i));
    end
    // Store followed by a load of the same word in the next cycle
    idx = written[3];
    drive_instr(1'b0, next_pc(), addr_for(idx), '0, WB_ALU, 1'b1, rand_word(), 5'd1);
    drive_instr(1'b1, next_pc(), addr_for(idx), 5'd20, WB_MEM, 1'b0, '0, 5'd4);
    // Store and load of one word in the same cycle read the old contents
    drive_instr(1'b1, next_pc(), addr_for(idx), 5'd21, WB_MEM, 1'b1, rand_word(), 5'd20);
  endtask

  task automatic random_phase();
    int        kind;
    ram_addr_t idx;
    reg_addr_t rd;
    reg_addr_t ra;
    for (int n = 0; n < RANDOM_LEN; n++) begin
      kind = {$random(seed)} % 7;
      rd = reg_addr_t'(rand_word());
      ra = reg_addr_t'(rand_word());
      idx = written[{$random(seed)} % written.size()];
      case (kind)
        0: drive_instr(1'b1, next_pc(), rand_word(), rd, WB_ALU, 1'b0, '0, ra);
        1: drive_instr(1'b1, next_pc(), addr_for(idx), rd, WB_MEM, 1'b0, '0, ra);
        2: drive_instr(1'b1, rand_word(), rand_word(), rd, WB_PC4, 1'b0, '0, ra);
        3: drive_instr(1'b1, next_pc(), rand_word(), rd, 2'b11, 1'b0, '0, ra);
        4: drive_instr(1'b1, next_pc(), rand_word(), '0, WB_PC4, 1'b0, '0, ra);
        5: begin
          if ({$random(seed)} % 2 == 0) begin
            idx = ram_addr_t'(rand_word());
            written.push_back(idx);
            drive_instr(1'b0, next_pc(), addr_for(idx), rd, WB_ALU, 1'b1, rand_word(), ra);
          end else begin
            drive_instr(1'b1, next_pc(), addr_for(idx), rd, WB_MEM, 1'b1, rand_word(), ra);
          end
        end
        default: drive_instr(1'b0, next_pc(), rand_word(), rd, WB_PC4, 1'b0, '0, ra);
      endcase
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    seed = 32'h97e0;
    pc_next = 32'h0000_1000;
    rst = 1'b1;
    reg_write_in = 1'b0;
    pc_in = '0;
    alu_out_in = '0;
    addr_c_in = '0;
    mem_to_reg_in = WB_ALU;
    mem_write = 1'b0;
    store_data = '0;
    raddr = '0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      raddr <= raddr + 5'd3;
    end
    rst <= 1'b0;
    sweep_regs();
    directed_phase();
    random_phase();
    repeat (DRAIN_CYCLES) drive_instr(1'b0, '0, '0, '0, WB_ALU, 1'b0, '0, '0);
    sweep_regs();
    repeat (DRAIN_CYCLES) @(posedge clk);
    prop_errors = DUT.u_mem_wb_reg.u_props.fail_count;
    $display("Errors: value mismatches %0d, assertion failures %0d, over %0d checks",
             value_errors, prop_errors, checks);
    if (value_errors == 0 && prop_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* mem_wb_path.f */
hdl/cpu_types_pkg.sv
hdl/mem_cfg_pkg.sv
hdl/wb_if.sv
hdl/mem_wb_reg.sv
hdl/data_ram.sv
hdl/write_back.sv
hdl/mem_wb_path.sv
tests/mem_wb_reg_props.sv
tests/mem_wb_checker.sv
tests/mem_wb_path_tb.sv

/* Bender.yml */
package:
  name: mem_wb_path

sources:
  # Design sources in compile order
  - files:
      - hdl/cpu_types_pkg.sv
      - hdl/mem_cfg_pkg.sv
      - hdl/wb_if.sv
      - hdl/mem_wb_reg.sv
      - hdl/data_ram.sv
      - hdl/write_back.sv
      - hdl/mem_wb_path.sv

  # Simulation sources
  - target: test
    files:
      - tests/mem_wb_reg_props.sv
      - tests/mem_wb_checker.sv
      - tests/mem_wb_path_tb.sv
